/* Makefile */
TOP := tb_idex_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module $(TOP) \
		-f idex_slice.f --Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* exu_alu.sv */
`timescale 1ns/100ps
module exu_alu (
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_imm,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_rs1,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_rs2,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_pc,
  input  idex_pkg::exu_sel_e             i_src_sel,
  input  idex_pkg::exu_opt_e             i_exopt,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_res,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_stdata
);

  import idex_pkg::*;

  logic [CPU_WIDTH-1:0] op_a;
  logic [CPU_WIDTH-1:0] op_b;
  logic [4:0]           shamt;

  // ====================
  always_comb begin
    op_a = i_rs1;
    op_b = i_imm;
    case (i_src_sel)
      REG_REG:  op_b = i_rs2;
      REG_IMM:  op_a = i_rs1;
      PC_IMM:   op_a = i_pc;
      default:  op_a = '0;  // zero plus immediate
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (i_exopt)
      ADD:     o_res = op_a + op_b;
      SUB:     o_res = op_a - op_b;
      AND:     o_res = op_a & op_b;
      OR:      o_res = op_a | op_b;
      XOR:     o_res = op_a ^ op_b;
      SLL:     o_res = op_a << shamt;
      SRL:     o_res = op_a >> shamt;
      SRA:     o_res = $signed(op_a) >>> shamt;
      SLT:     o_res = {{(CPU_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU:    o_res = {{(CPU_WIDTH-1){1'b0}}, op_a < op_b};
      default: o_res = op_b;  // PASSB
    endcase
  end

  assign o_stdata = i_rs2;  // only meaningful when sten is set

endmodule

/* hazard_ctrl.sv */
`timescale 1ns/100ps
module hazard_ctrl (
  input  logic                           i_idu_vld,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_rs1id,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_rs2id,
  input  logic                           i_rs1_used,
  input  logic                           i_rs2_used,
  input  logic                           i_exu_lden,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_exu_rdid,
  output logic                           o_bubble,
  output logic                           o_stall
);

  logic load_pending;
  logic hit_rs1;
  logic hit_rs2;
  logic load_use;

  // a load into x0 never produces a value anyone waits for
  assign load_pending = i_exu_lden && (i_exu_rdid != '0);

  assign hit_rs1 = i_rs1_used && (i_rs1id == i_exu_rdid);
  assign hit_rs2 = i_rs2_used && (i_rs2id == i_exu_rdid);

  assign load_use = i_idu_vld && load_pending && (hit_rs1 || hit_rs2);

  // ====================
  // the dependent instruction waits one cycle at the decoder input
  assign o_stall  = load_use;
  assign o_bubble = load_use || !i_idu_vld;  // also covers empty slots and unknown opcodes

endmodule

/* idex_core.sv */
`timescale 1ns/100ps
module idex_core (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_inst_vld,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_inst,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_pc,
  input  logic                           i_wb_wen,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_wb_rdid,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_wb_data,

  output logic                           o_stall,
  output logic                           o_exu_vld,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_res,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_stdata,
  output logic [idex_pkg::REG_ADDRW-1:0] o_exu_rdid,
  output logic                           o_exu_rdwen,
  output logic                           o_exu_lden,
  output logic                           o_exu_sten,
  output logic [2:0]                     o_exu_func3,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_pc
);

  import idex_pkg::*;

  // ====================
  // decode stage
  logic                 idu_vld;
  logic [CPU_WIDTH-1:0] idu_imm;
  logic [REG_ADDRW-1:0] rs1id;
  logic [REG_ADDRW-1:0] rs2id;
  logic                 rs1_used;
  logic                 rs2_used;
  logic [REG_ADDRW-1:0] idu_rdid;
  logic                 idu_rdwen;
  exu_sel_e             idu_src_sel;
  exu_opt_e             idu_exopt;
  logic [2:0]           idu_func3;
  logic                 idu_lden;
  logic                 idu_sten;
  logic [CPU_WIDTH-1:0] idu_pc;
  logic [CPU_WIDTH-1:0] rs1_data;
  logic [CPU_WIDTH-1:0] rs2_data;
  logic                 bubble;

  // execute stage
  logic [CPU_WIDTH-1:0] exu_imm;
  logic [CPU_WIDTH-1:0] exu_rs1;
  logic [CPU_WIDTH-1:0] exu_rs2;
  exu_sel_e             exu_src_sel;
  exu_opt_e             exu_exopt;

  idu_decode idu_decode_i (
    .i_inst_vld (i_inst_vld),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .o_vld      (idu_vld),
    .o_imm      (idu_imm),
    .o_rs1id    (rs1id),
    .o_rs2id    (rs2id),
    .o_rs1_used (rs1_used),
    .o_rs2_used (rs2_used),
    .o_rdid     (idu_rdid),
    .o_rdwen    (idu_rdwen),
    .o_src_sel  (idu_src_sel),
    .o_exopt    (idu_exopt),
    .o_func3    (idu_func3),
    .o_lden     (idu_lden),
    .o_sten     (idu_sten),
    .o_pc       (idu_pc)
  );

  idu_regfile idu_regfile_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wen    (i_wb_wen),
    .i_wid    (i_wb_rdid),
    .i_wdata  (i_wb_data),
    .i_rid1   (rs1id),
    .i_rid2   (rs2id),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data)
  );

  // compares against the load currently sitting in ID/EX
  hazard_ctrl hazard_ctrl_i (
    .i_idu_vld  (idu_vld),
    .i_rs1id    (rs1id),
    .i_rs2id    (rs2id),
    .i_rs1_used (rs1_used),
    .i_rs2_used (rs2_used),
    .i_exu_lden (o_exu_lden),
    .i_exu_rdid (o_exu_rdid),
    .o_bubble   (bubble),
    .o_stall    (o_stall)
  );

  pipe_id_ex pipe_id_ex_i (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_bubble      (bubble),
    .i_idu_vld     (idu_vld),
    .i_idu_imm     (idu_imm),
    .i_idu_rs1     (rs1_data),
    .i_idu_rs2     (rs2_data),
    .i_idu_rdid    (idu_rdid),
    .i_idu_rdwen   (idu_rdwen),
    .i_idu_src_sel (idu_src_sel),
    .i_idu_exopt   (idu_exopt),
    .i_idu_func3   (idu_func3),
    .i_idu_lden    (idu_lden),
    .i_idu_sten    (idu_sten),
    .i_idu_pc      (idu_pc),
    .o_exu_vld     (o_exu_vld),
    .o_exu_imm     (exu_imm),
    .o_exu_rs1     (exu_rs1),
    .o_exu_rs2     (exu_rs2),
    .o_exu_rdid    (o_exu_rdid),
    .o_exu_rdwen   (o_exu_rdwen),
    .o_exu_src_sel (exu_src_sel),
    .o_exu_exopt   (exu_exopt),
    .o_exu_func3   (o_exu_func3),
    .o_exu_lden    (o_exu_lden),
    .o_exu_sten    (o_exu_sten),
    .o_exu_pc      (o_exu_pc)
  );

  exu_alu exu_alu_i (
    .i_imm     (exu_imm),
    .i_rs1     (exu_rs1),
    .i_rs2     (exu_rs2),
    .i_pc      (o_exu_pc),
    .i_src_sel (exu_src_sel),
    .i_exopt   (exu_exopt),
    .o_res     (o_exu_res),
    .o_stdata  (o_exu_stdata)
  );

endmodule

/* idex_pkg.sv */
package idex_pkg;

  localparam int CPU_WIDTH = 32;
  localparam int REG_ADDRW = 5;

  // ====================
  // RV32I major opcodes handled by this slice
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111
  } opcode_e;

  // ====================
  // execute unit operations
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    PASSB  // operand b goes straight to the result for lui
  } exu_opt_e;

  // operand a / operand b sources
  typedef enum logic [1:0] {
    REG_REG,
    REG_IMM,
    PC_IMM,
    ZERO_IMM
  } exu_sel_e;

  // ====================
  // a bubble computes 0 + 0 and writes nothing
  localparam exu_opt_e BUBBLE_OPT = ADD;
  localparam exu_sel_e BUBBLE_SEL = ZERO_IMM;

endpackage

/* idex_slice.f */
idex_pkg.sv
idu_decode.sv
idu_regfile.sv
hazard_ctrl.sv
pipe_id_ex.sv
exu_alu.sv
idex_core.sv
tb_idex_core.sv

/* idu_decode.sv */
`timescale 1ns/100ps
module idu_decode (
  input  logic                           i_inst_vld,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_inst,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_pc,

  output logic                           o_vld,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_imm,
  output logic [idex_pkg::REG_ADDRW-1:0] o_rs1id,
  output logic [idex_pkg::REG_ADDRW-1:0] o_rs2id,
  output logic                           o_rs1_used,
  output logic                           o_rs2_used,
  output logic [idex_pkg::REG_ADDRW-1:0] o_rdid,
  output logic                           o_rdwen,
  output idex_pkg::exu_sel_e             o_src_sel,
  output idex_pkg::exu_opt_e             o_exopt,
  output logic [2:0]                     o_func3,
  output logic                           o_lden,
  output logic                           o_sten,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_pc
);

  import idex_pkg::*;

  opcode_e              opcode;
  logic [2:0]           func3;
  logic                 func7_b5;
  logic                 is_op;
  logic                 supported;
  logic [CPU_WIDTH-1:0] imm_i;
  logic [CPU_WIDTH-1:0] imm_s;
  logic [CPU_WIDTH-1:0] imm_u;
  exu_opt_e             alu_op;

  assign opcode   = opcode_e'(i_inst[6:0]);
  assign func3    = i_inst[14:12];
  assign func7_b5 = i_inst[30];  // selects sub and sra
  assign is_op    = (opcode == OP);

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_u = {i_inst[31:12], 12'b0};

  assign o_rdid  = i_inst[11:7];
  assign o_rs1id = i_inst[19:15];
  assign o_rs2id = i_inst[24:20];
  assign o_func3 = func3;
  assign o_pc    = i_pc;
  assign o_vld   = i_inst_vld && supported;

  // ====================
  // arithmetic operation from funct3, shared by OP and OP-IMM
  always_comb begin
    case (func3)
      3'b000:  alu_op = (is_op && func7_b5) ? SUB : ADD;  // no subi in OP-IMM
      3'b001:  alu_op = SLL;
      3'b010:  alu_op = SLT;
      3'b011:  alu_op = SLTU;
      3'b100:  alu_op = XOR;
      3'b101:  alu_op = func7_b5 ? SRA : SRL;
      3'b110:  alu_op = OR;
      default: alu_op = AND;
    endcase
  end

  // ====================
  always_comb begin
    supported  = 1'b1;
    o_imm      = '0;
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    o_rdwen    = 1'b0;
    o_src_sel  = REG_REG;
    o_exopt    = ADD;
    o_lden     = 1'b0;
    o_sten     = 1'b0;
    case (opcode)
      OP: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_rdwen    = 1'b1;
        o_exopt    = alu_op;
      end
      OP_IMM: begin
        o_imm      = imm_i;  // shift amount sits in the low 5 bits
        o_rs1_used = 1'b1;
        o_rdwen    = 1'b1;
        o_src_sel  = REG_IMM;
        o_exopt    = alu_op;
      end
      LUI: begin
        o_imm     = imm_u;
        o_rdwen   = 1'b1;
        o_src_sel = ZERO_IMM;
        o_exopt   = PASSB;
      end
      AUIPC: begin
        o_imm     = imm_u;
        o_rdwen   = 1'b1;
        o_src_sel = PC_IMM;
      end
      LOAD: begin
        o_imm      = imm_i;
        o_rs1_used = 1'b1;
        o_rdwen    = 1'b1;
        o_src_sel  = REG_IMM;
        o_lden     = 1'b1;
      end
      STORE: begin
        o_imm      = imm_s;
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;  // store data comes from rs2
        o_src_sel  = REG_IMM;
        o_sten     = 1'b1;
      end
      default: supported = 1'b0;
    endcase
  end

endmodule

/* idu_regfile.sv */
`timescale 1ns/100ps
module idu_regfile (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_wen,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_wid,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_wdata,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_rid1,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_rid2,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_rdata1,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_rdata2
);

  import idex_pkg::*;

  logic [CPU_WIDTH-1:0] regs [1:31];  // x0 has no storage

  // x0 reads zero and a write in flight to the same register wins
  function automatic logic [CPU_WIDTH-1:0] read_port(input logic [REG_ADDRW-1:0] rid);
    logic [CPU_WIDTH-1:0] val;
    if (rid == '0) val = '0;
    else if (i_wen && (i_wid == rid)) val = i_wdata;
    else val = regs[rid];
    return val;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wid != '0)) begin
      regs[i_wid] <= i_wdata;
    end
  end

  always_comb begin
    o_rdata1 = read_port(i_rid1);
    o_rdata2 = read_port(i_rid2);
  end

endmodule

/* pipe_id_ex.sv */
`timescale 1ns/100ps
module pipe_id_ex (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_bubble,

  input  logic                           i_idu_vld,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_idu_imm,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_idu_rs1,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_idu_rs2,
  input  logic [idex_pkg::REG_ADDRW-1:0] i_idu_rdid,
  input  logic                           i_idu_rdwen,
  input  idex_pkg::exu_sel_e             i_idu_src_sel,
  input  idex_pkg::exu_opt_e             i_idu_exopt,
  input  logic [2:0]                     i_idu_func3,
  input  logic                           i_idu_lden,
  input  logic                           i_idu_sten,
  input  logic [idex_pkg::CPU_WIDTH-1:0] i_idu_pc,

  output logic                           o_exu_vld,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_imm,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_rs1,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_rs2,
  output logic [idex_pkg::REG_ADDRW-1:0] o_exu_rdid,
  output logic                           o_exu_rdwen,
  output idex_pkg::exu_sel_e             o_exu_src_sel,
  output idex_pkg::exu_opt_e             o_exu_exopt,
  output logic [2:0]                     o_exu_func3,
  output logic                           o_exu_lden,
  output logic                           o_exu_sten,
  output logic [idex_pkg::CPU_WIDTH-1:0] o_exu_pc
);

  import idex_pkg::*;

  // ====================
  // fields replaced by bubble defaults
  always_ff @(posedge i_clk) begin
    if (i_rst || i_bubble) begin
      o_exu_vld     <= 1'b0;
      o_exu_imm     <= '0;
      o_exu_rs1     <= '0;
      o_exu_rs2     <= '0;
      o_exu_rdid    <= '0;
      o_exu_rdwen   <= 1'b0;
      o_exu_src_sel <= BUBBLE_SEL;
      o_exu_exopt   <= BUBBLE_OPT;
      o_exu_lden    <= 1'b0;
      o_exu_sten    <= 1'b0;
    end else begin
      o_exu_vld     <= i_idu_vld;
      o_exu_imm     <= i_idu_imm;
      o_exu_rs1     <= i_idu_rs1;
      o_exu_rs2     <= i_idu_rs2;
      o_exu_rdid    <= i_idu_rdid;
      o_exu_rdwen   <= i_idu_rdwen;
      o_exu_src_sel <= i_idu_src_sel;
      o_exu_exopt   <= i_idu_exopt;
      o_exu_lden    <= i_idu_lden;
      o_exu_sten    <= i_idu_sten;
    end
  end

  // func3 and pc keep flowing through a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_exu_func3 <= '0;
      o_exu_pc    <= '0;
    end else begin
      o_exu_func3 <= i_idu_func3;
      o_exu_pc    <= i_idu_pc;
    end
  end

endmodule

/* tb_idex_core.sv */
`timescale 1ns/100ps
module tb_idex_core;

  import idex_pkg::*;

  typedef struct packed {
    logic        vld;
    logic [31:0] res;
    logic [31:0] stdata;
    logic [31:0] pc;
    logic [4:0]  rdid;
    logic        rdwen;
    logic        lden;
    logic        sten;
    logic [2:0]  func3;
  } exp_t;

  logic        clk;
  logic        i_rst;
  logic        i_inst_vld;
  logic [31:0] i_inst;
  logic [31:0] i_pc;
  logic        i_wb_wen;
  logic [4:0]  i_wb_rdid;
  logic [31:0] i_wb_data;
  logic        o_stall;
  logic        o_exu_vld;
  logic [31:0] o_exu_res;
  logic [31:0] o_exu_stdata;
  logic [4:0]  o_exu_rdid;
  logic        o_exu_rdwen;
  logic        o_exu_lden;
  logic        o_exu_sten;
  logic [2:0]  o_exu_func3;
  logic [31:0] o_exu_pc;

  logic [31:0] mirror [0:31];  // x0 entry is never written
  logic [4:0]  pipe_ld_rd;     // rd of a load now held in ID/EX, zero otherwise
  logic [31:0] pc_cnt;
  exp_t        exp_q[$];
  integer      seed;
  int          errors;
  int          checks;

  idex_core idex_core_i (
    .i_clk        (clk),
    .i_rst        (i_rst),
    .i_inst_vld   (i_inst_vld),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .i_wb_wen     (i_wb_wen),
    .i_wb_rdid    (i_wb_rdid),
    .i_wb_data    (i_wb_data),
    .o_stall      (o_stall),
    .o_exu_vld    (o_exu_vld),
    .o_exu_res    (o_exu_res),
    .o_exu_stdata (o_exu_stdata),
    .o_exu_rdid   (o_exu_rdid),
    .o_exu_rdwen  (o_exu_rdwen),
    .o_exu_lden   (o_exu_lden),
    .o_exu_sten   (o_exu_sten),
    .o_exu_func3  (o_exu_func3),
    .o_exu_pc     (o_exu_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ====================
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // ====================
  function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // expected execute outputs from the mirror, as seen in the consuming cycle
  function automatic exp_t ref_exec(input logic [31:0] inst, input logic [31:0] pc);
    exp_t        e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    opc   = inst[6:0];
    f3    = inst[14:12];
    a     = mirror[inst[19:15]];
    b     = mirror[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_u = {inst[31:12], 12'h000};
    e        = '0;
    e.vld    = 1'b1;
    e.rdid   = inst[11:7];
    e.func3  = f3;
    e.pc     = pc;
    e.stdata = b;
    e.rdwen  = 1'b1;
    case (opc)
      OP:     e.res = compute_alu(f3, inst[30], a, b);
      OP_IMM: e.res = compute_alu(f3, inst[30] && (f3 == 3'b101), a, imm_i);  // no subi
      LUI:    e.res = imm_u;
      AUIPC:  e.res = pc + imm_u;
      LOAD: begin
        e.res  = a + imm_i;
        e.lden = 1'b1;
      end
      STORE: begin
        e.res   = a + imm_s;
        e.sten  = 1'b1;
        e.rdwen = 1'b0;
      end
      default: e.vld = 1'b0;
    endcase
    return e;
  endfunction

  // load-use rule against the load held in ID/EX
  function automatic logic predict_stall(input logic [31:0] inst, input logic [4:0] ld_rd);
    logic [6:0] opc;
    logic       use1;
    logic       use2;
    opc  = inst[6:0];
    use1 = (opc == OP) || (opc == OP_IMM) || (opc == LOAD) || (opc == STORE);
    use2 = (opc == OP) || (opc == STORE);
    return (ld_rd != 5'd0) &&
           ((use1 && (inst[19:15] == ld_rd)) || (use2 && (inst[24:20] == ld_rd)));
  endfunction

  // ====================
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
    @(posedge clk);
    i_inst_vld <= 1'b0;
    i_wb_wen   <= 1'b1;
    i_wb_rdid  <= rd;
    i_wb_data  <= data;
    if (rd != 5'd0) mirror[rd] = data;
    pipe_ld_rd = 5'd0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      i_inst_vld <= 1'b0;
      i_wb_wen   <= 1'b0;
      pipe_ld_rd = 5'd0;
    end
  endtask

  // drives one instruction, optionally with a writeback in the same cycle
  task automatic issue(input logic [31:0] inst, input logic wen, input logic [4:0] wrd,
                       input logic [31:0] wdata, output int stalls);
    exp_t e;
    int   waited;
    @(posedge clk);
    i_inst_vld <= 1'b1;
    i_inst     <= inst;
    i_pc       <= pc_cnt;
    i_wb_wen   <= wen;
    i_wb_rdid  <= wrd;
    i_wb_data  <= wdata;
    if (wen && (wrd != 5'd0)) mirror[wrd] = wdata;
    stalls = 0;
    waited = 0;
    @(negedge clk);
    check_val("o_stall", 32'(o_stall), 32'(predict_stall(inst, pipe_ld_rd)));
    while (o_stall) begin
      if (waited > 4) report_timeout("o_stall to drop");
      stalls++;
      waited++;
      @(posedge clk);
      i_wb_wen <= 1'b0;
      pipe_ld_rd = 5'd0;  // a bubble went in
      @(negedge clk);
      check_val("o_exu_vld", 32'(o_exu_vld), 32'd0);
      check_val("o_stall", 32'(o_stall), 32'(predict_stall(inst, pipe_ld_rd)));
    end
    e = ref_exec(inst, pc_cnt);
    if (e.vld) exp_q.push_back(e);
    pipe_ld_rd = (e.vld && e.lden) ? inst[11:7] : 5'd0;
    pc_cnt = pc_cnt + 32'd4;
  endtask

  task automatic send(input logic [31:0] inst);
    int st;
    issue(inst, 1'b0, 5'd0, 32'd0, st);
  endtask

  // ====================
  always @(negedge clk) begin : compare_proc
    exp_t e;
    if (!i_rst && o_exu_vld) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("o_exu_vld high at %0t with no instruction expected", $time);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_val("o_exu_res", o_exu_res, e.res);
        check_val("o_exu_rdid", 32'(o_exu_rdid), 32'(e.rdid));
        check_val("o_exu_rdwen", 32'(o_exu_rdwen), 32'(e.rdwen));
        check_val("o_exu_lden", 32'(o_exu_lden), 32'(e.lden));
        check_val("o_exu_sten", 32'(o_exu_sten), 32'(e.sten));
        check_val("o_exu_func3", 32'(o_exu_func3), 32'(e.func3));
        check_val("o_exu_pc", o_exu_pc, e.pc);
        if (e.sten) check_val("o_exu_stdata", o_exu_stdata, e.stdata);
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] val;
    logic [31:0] inst;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          st;
    int          waited;
    seed       = 32'h93a2_404c;
    errors     = 0;
    checks     = 0;
    pc_cnt     = 32'h0000_1000;
    pipe_ld_rd = 5'd0;
    i_rst      = 1'b1;
    i_inst_vld = 1'b0;
    i_inst     = 32'd0;
    i_pc       = 32'd0;
    i_wb_wen   = 1'b0;
    i_wb_rdid  = 5'd0;
    i_wb_data  = 32'd0;
    for (int k = 0; k < 32; k++) mirror[k] = 32'd0;

    // ==================== reset
    repeat (10) @(posedge clk);
    i_rst <= 1'b0;
    @(negedge clk);
    check_val("o_exu_vld", 32'(o_exu_vld), 32'd0);
    check_val("o_exu_rdwen", 32'(o_exu_rdwen), 32'd0);
    check_val("o_exu_lden", 32'(o_exu_lden), 32'd0);
    check_val("o_exu_sten", 32'(o_exu_sten), 32'd0);
    check_val("o_stall", 32'(o_stall), 32'd0);

    // every register written once, x0 included, then read back through add
    for (int k = 0; k < 32; k++) begin
      rnd = $random(seed);
      write_reg(k[4:0], rnd);
    end
    for (int k = 0; k < 32; k++) begin
      send(r_type(7'h00, 5'd0, k[4:0], 3'b000, 5'd1));
      send(r_type(7'h00, k[4:0], 5'd0, 3'b110, 5'd2));
    end

    // ==================== random OP and OP-IMM
    write_reg(5'd5, 32'hf000_0f00);
    write_reg(5'd6, 32'h0000_0024);  // shift of 36 uses only 4
    send(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd3));
    send(r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd3));
    send(r_type(7'h00, 5'd6, 5'd5, 3'b101, 5'd3));
    send(r_type(7'h20, 5'd6, 5'd5, 3'b101, 5'd3));
    for (int n = 0; n < 300; n++) begin
      rnd = $random(seed);
      val = $random(seed);
      f3  = rnd[2:0];
      f7  = (((f3 == 3'b000) || (f3 == 3'b101)) && rnd[3]) ? 7'h20 : 7'h00;
      imm = ((f3 == 3'b001) || (f3 == 3'b101)) ? {f7, rnd[8:4]} : rnd[15:4];
      if (rnd[16]) inst = r_type(f7, rnd[21:17], rnd[26:22], f3, rnd[31:27]);
      else inst = i_type(imm, rnd[26:22], f3, rnd[31:27], OP_IMM);
      issue(inst, (n % 4) == 3, val[4:0], val, st);
    end

    // ==================== upper immediates, loads and stores
    for (int n = 0; n < 30; n++) begin
      rnd = $random(seed);
      send(u_type(rnd[31:12], rnd[11:7], rnd[0] ? LUI : AUIPC));
    end
    for (int n = 0; n < 60; n++) begin
      rnd = $random(seed);
      if (rnd[0]) send(i_type(rnd[31:20], rnd[19:15], rnd[14:12], rnd[11:7], LOAD));
      else send(s_type(rnd[31:20], rnd[24:20], rnd[19:15], rnd[14:12]));
    end

    // ==================== load-use
    send(i_type(12'h010, 5'd7, 3'b010, 5'd9, LOAD));
    issue(r_type(7'h00, 5'd9, 5'd3, 3'b000, 5'd10), 1'b0, 5'd0, 32'd0, st);
    check_val("stall cycles", 32'(st), 32'd1);
    send(i_type(12'h7fc, 5'd4, 3'b000, 5'd11, LOAD));
    issue(s_type(12'h004, 5'd11, 5'd2, 3'b010), 1'b0, 5'd0, 32'd0, st);
    check_val("stall cycles", 32'(st), 32'd1);
    send(i_type(12'h004, 5'd4, 3'b001, 5'd12, LOAD));
    issue(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd12), 1'b0, 5'd0, 32'd0, st);
    check_val("stall cycles", 32'(st), 32'd0);
    send(i_type(12'h008, 5'd4, 3'b010, 5'd0, LOAD));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd13), 1'b0, 5'd0, 32'd0, st);
    check_val("stall cycles", 32'(st), 32'd0);

    // ==================== same-cycle writeback and an unknown opcode
    val = $random(seed);
    issue(r_type(7'h00, 5'd0, 5'd8, 3'b000, 5'd1), 1'b1, 5'd8, val, st);
    send(r_type(7'h00, 5'd8, 5'd0, 3'b110, 5'd1));
    issue(32'h0000_006f, 1'b0, 5'd0, 32'd0, st);
    check_val("stall cycles", 32'(st), 32'd0);
    send(r_type(7'h20, 5'd8, 5'd5, 3'b000, 5'd14));

    idle(2);
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > 20) report_timeout("the last results");
      @(negedge clk);
      waited++;
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
